/* logic/serial_link_defines.svh */
// Serial link build-time constants
// Lane count, word width, credit depth and divider limits

`ifndef SERIAL_LINK_DEFINES_SVH
`define SERIAL_LINK_DEFINES_SVH

// Wire side
`define SL_NUM_LANES      4

// Message word and credit counts
`define SL_DATA_W         32
`define SL_NUM_CREDITS    4
`define SL_CREDIT_W       3

// Forwarded clock divider
`define SL_MAX_CLK_DIV    64
`define SL_DIV_W          7
`define SL_RESET_CLK_DIV  4

// 40 payload bits over 4 lanes
`define SL_PAYLOAD_BEATS  10

`endif

/* logic/serial_link_pkg.sv */
// Serial link shared types
// Payload tag, register address map and payload layout

`default_nettype none

`include "serial_link_defines.svh"

package serial_link_pkg;

  // Payload kinds on the link
  typedef enum logic [1:0] {
    TAG_NONE   = 2'd0,
    TAG_DATA   = 2'd1,
    TAG_CREDIT = 2'd2
  } tag_e;

  // Register map
  typedef enum logic [1:0] {
    CFG_CTRL    = 2'd0,
    CFG_CLK_DIV = 2'd1,
    CFG_STATUS  = 2'd2
  } cfg_addr_e;

  // One payload, sent least significant beat first
  typedef struct packed {
    tag_e                    tag;
    logic [`SL_CREDIT_W-1:0] credit;
    logic [2:0]              rsvd;
    logic [`SL_DATA_W-1:0]   data;
  } payload_t;

endpackage

`default_nettype wire

/* logic/serial_link_network.sv */
// Serial link network layer
// Message register, credit flow control, credit return and receive FIFO

`timescale 1ns/1ps
`default_nettype none

`include "serial_link_defines.svh"

module serial_link_network
  import serial_link_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic                    link_en_i,
  // User side
  input  wire logic                    msg_send_i,
  input  wire logic [`SL_DATA_W-1:0]   msg_data_i,
  output logic                         tx_ready_o,
  output logic                         rx_valid_o,
  output logic [`SL_DATA_W-1:0]        rx_data_o,
  input  wire logic                    rx_pop_i,
  // Data link side
  output payload_t                     tx_payload_o,
  output logic                         tx_payload_valid_o,
  input  wire logic                    tx_busy_i,
  input  wire payload_t                rx_payload_i,
  input  wire logic                    rx_payload_valid_i,
  // Status
  output logic [`SL_CREDIT_W-1:0]      credits_o,
  output logic [`SL_CREDIT_W-1:0]      rx_fill_o
);

  localparam int unsigned PTR_W = $clog2(`SL_NUM_CREDITS);

  logic                    msg_valid_q;
  logic [`SL_DATA_W-1:0]   msg_data_q;
  logic [`SL_CREDIT_W-1:0] credits_q;
  logic [`SL_CREDIT_W-1:0] pending_q;
  logic [`SL_CREDIT_W-1:0] rx_credit;
  logic                    send_data;

  logic [`SL_DATA_W-1:0]   fifo_mem [`SL_NUM_CREDITS];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [`SL_CREDIT_W-1:0] fifo_cnt_q;
  logic                    fifo_push;
  logic                    fifo_pop;

  ////////////////////////////////////////////////////////////
  // Transmit side
  ////////////////////////////////////////////////////////////

  // One message in flight between user and data link
  assign tx_ready_o = link_en_i && (credits_q != '0) && !msg_valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      msg_valid_q <= 1'b0;
    end else if (msg_send_i && tx_ready_o) begin
      msg_valid_q <= 1'b1;
    end else if (send_data) begin
      msg_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (msg_send_i && tx_ready_o) begin
      msg_data_q <= msg_data_i;
    end
  end

  // Data wins over a credit-only payload, both carry the pending credits
  always_comb begin
    tx_payload_o        = '0;
    tx_payload_o.credit = pending_q;
    tx_payload_valid_o  = 1'b0;
    if (!tx_busy_i) begin
      if (msg_valid_q) begin
        tx_payload_o.tag   = TAG_DATA;
        tx_payload_o.data  = msg_data_q;
        tx_payload_valid_o = 1'b1;
      end else if (pending_q != '0) begin
        tx_payload_o.tag   = TAG_CREDIT;
        tx_payload_valid_o = 1'b1;
      end
    end
  end

  assign send_data = tx_payload_valid_o && msg_valid_q;

  ////////////////////////////////////////////////////////////
  // Credit accounting
  ////////////////////////////////////////////////////////////

  // Credits returned by the far side
  assign rx_credit = (rx_payload_valid_i && rx_payload_i.tag != TAG_NONE) ?
                     rx_payload_i.credit : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credits_q <= `SL_CREDIT_W'(`SL_NUM_CREDITS);
      pending_q <= '0;
    end else begin
      credits_q <= credits_q - `SL_CREDIT_W'(send_data) + rx_credit;
      // Pending credits are handed over on every payload sent
      pending_q <= (tx_payload_valid_o ? '0 : pending_q) + `SL_CREDIT_W'(fifo_pop);
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive FIFO
  ////////////////////////////////////////////////////////////

  assign fifo_push = rx_payload_valid_i && (rx_payload_i.tag == TAG_DATA);
  assign fifo_pop  = rx_pop_i && rx_valid_o;

  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr_q] <= rx_payload_i.data;
    end
  end

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end else begin
      if (fifo_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      fifo_cnt_q <= fifo_cnt_q + `SL_CREDIT_W'(fifo_push) - `SL_CREDIT_W'(fifo_pop);
    end
  end

  assign rx_valid_o = (fifo_cnt_q != '0);
  assign rx_data_o  = fifo_mem[rd_ptr_q];
  assign credits_o  = credits_q;
  assign rx_fill_o  = fifo_cnt_q;

  // Credits returned from the far end can never exceed what was issued
  credit_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits_q <= `SL_NUM_CREDITS)
    else $error("credit counter above SL_NUM_CREDITS");

  // Sender credit loop guarantees room for every received data payload
  fifo_no_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fifo_push |-> (fifo_cnt_q < `SL_NUM_CREDITS))
    else $error("receive FIFO written while full");

endmodule

`default_nettype wire

/* logic/serial_link_data_link.sv */
// Serial link data link layer
// Payload to beat serializer and beat to payload deserializer

`timescale 1ns/1ps
`default_nettype none

`include "serial_link_defines.svh"

module serial_link_data_link
  import serial_link_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  // Network side
  input  wire payload_t                  tx_payload_i,
  input  wire logic                      tx_payload_valid_i,
  output logic                           tx_busy_o,
  output payload_t                       rx_payload_o,
  output logic                           rx_payload_valid_o,
  // Physical side
  output logic [`SL_NUM_LANES-1:0]       beat_data_o,
  output logic                           beat_send_o,
  input  wire logic                      beat_busy_i,
  input  wire logic [`SL_NUM_LANES-1:0]  rx_beat_i,
  input  wire logic                      rx_beat_valid_i
);

  localparam int unsigned PAYLOAD_W = $bits(payload_t);
  localparam int unsigned CNT_W     = $clog2(`SL_PAYLOAD_BEATS + 1);

  logic [PAYLOAD_W-1:0] tx_shift_q;
  logic [CNT_W-1:0]     tx_cnt_q;
  logic [PAYLOAD_W-1:0] rx_shift_q;
  logic [CNT_W-1:0]     rx_cnt_q;
  logic                 rx_done_q;
  logic                 rx_last;

  ////////////////////////////////////////////////////////////
  // Transmit, least significant beat first
  ////////////////////////////////////////////////////////////

  assign tx_busy_o   = (tx_cnt_q != '0);
  assign beat_send_o = tx_busy_o && !beat_busy_i;
  assign beat_data_o = tx_shift_q[`SL_NUM_LANES-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_cnt_q <= '0;
    end else if (tx_payload_valid_i) begin
      tx_cnt_q <= CNT_W'(`SL_PAYLOAD_BEATS);
    end else if (beat_send_o) begin
      tx_cnt_q <= tx_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_payload_valid_i) begin
      tx_shift_q <= tx_payload_i;
    end else if (beat_send_o) begin
      tx_shift_q <= tx_shift_q >> `SL_NUM_LANES;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive
  ////////////////////////////////////////////////////////////

  assign rx_last = (rx_cnt_q == CNT_W'(`SL_PAYLOAD_BEATS - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_cnt_q  <= '0;
      rx_done_q <= 1'b0;
    end else begin
      rx_done_q <= rx_beat_valid_i && rx_last;
      if (rx_beat_valid_i) begin
        rx_cnt_q <= rx_last ? '0 : rx_cnt_q + 1'b1;
      end
    end
  end

  // New beats enter at the top and move down
  always_ff @(posedge clk_i) begin
    if (rx_beat_valid_i) begin
      rx_shift_q <= {rx_beat_i, rx_shift_q[PAYLOAD_W-1:`SL_NUM_LANES]};
    end
  end

  assign rx_payload_o       = payload_t'(rx_shift_q);
  assign rx_payload_valid_o = rx_done_q;

  // Network must wait for the serializer to drain
  no_payload_while_busy_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tx_payload_valid_i |-> !tx_busy_o)
    else $error("payload handed over while serializer busy");

endmodule

`default_nettype wire

/* logic/serial_link_physical.sv */
// Serial link physical layer
// Clock divider, forwarded clock and lane driver
// Forwarded clock synchronizer and rising edge beat sampler

`timescale 1ns/1ps
`default_nettype none

`include "serial_link_defines.svh"

module serial_link_physical (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire logic [`SL_DIV_W-1:0]      clk_div_i,
  // Data link side
  input  wire logic [`SL_NUM_LANES-1:0]  beat_data_i,
  input  wire logic                      beat_send_i,
  output logic                           beat_busy_o,
  output logic [`SL_NUM_LANES-1:0]       rx_beat_o,
  output logic                           rx_beat_valid_o,
  // Wire side
  output logic [`SL_NUM_LANES-1:0]       lanes_o,
  output logic                           fwd_clk_o,
  input  wire logic [`SL_NUM_LANES-1:0]  lanes_i,
  input  wire logic                      fwd_clk_i
);

  logic                     busy_q;
  logic [`SL_DIV_W-1:0]     phase_q;
  logic [`SL_DIV_W-1:0]     phase_next;
  logic [`SL_DIV_W-1:0]     half_div;
  logic                     last_phase;
  logic                     load;
  logic                     fwd_clk_q;
  logic [`SL_NUM_LANES-1:0] lanes_q;

  logic [2:0]               fwd_sync_q;
  logic                     fwd_rise;
  logic [`SL_NUM_LANES-1:0] lanes_sync1_q;
  logic [`SL_NUM_LANES-1:0] lanes_sync2_q;
  logic [`SL_NUM_LANES-1:0] rx_beat_q;
  logic                     rx_beat_valid_q;

  ////////////////////////////////////////////////////////////
  // Transmit
  ////////////////////////////////////////////////////////////

  assign half_div   = clk_div_i >> 1;
  assign phase_next = phase_q + 1'b1;
  // A shrinking divider must not trap the counter
  assign last_phase = (phase_q >= clk_div_i - 1'b1);

  // Next beat may load in the last phase, so a beat lasts clk_div cycles
  assign beat_busy_o = busy_q && !last_phase;
  assign load        = beat_send_i && !beat_busy_o;

  // Lanes change with the falling forwarded clock, rise at half the beat
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      phase_q   <= '0;
      fwd_clk_q <= 1'b0;
      lanes_q   <= '0;
    end else if (load) begin
      busy_q    <= 1'b1;
      phase_q   <= '0;
      fwd_clk_q <= 1'b0;
      lanes_q   <= beat_data_i;
    end else if (busy_q) begin
      if (last_phase) begin
        busy_q    <= 1'b0;
        phase_q   <= '0;
        fwd_clk_q <= 1'b0;
      end else begin
        phase_q   <= phase_next;
        fwd_clk_q <= (phase_next >= half_div);
      end
    end
  end

  assign lanes_o   = lanes_q;
  assign fwd_clk_o = fwd_clk_q;

  ////////////////////////////////////////////////////////////
  // Receive
  ////////////////////////////////////////////////////////////

  // Two sync stages plus one history bit for edge detection
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fwd_sync_q      <= '0;
      rx_beat_valid_q <= 1'b0;
    end else begin
      fwd_sync_q      <= {fwd_sync_q[1:0], fwd_clk_i};
      rx_beat_valid_q <= fwd_rise;
    end
  end

  assign fwd_rise = fwd_sync_q[1] && !fwd_sync_q[2];

  // Lanes go through the same depth as the clock to stay aligned
  always_ff @(posedge clk_i) begin
    lanes_sync1_q <= lanes_i;
    lanes_sync2_q <= lanes_sync1_q;
    if (fwd_rise) begin
      rx_beat_q <= lanes_sync2_q;
    end
  end

  assign rx_beat_o       = rx_beat_q;
  assign rx_beat_valid_o = rx_beat_valid_q;

  // Register block must hand over an even divider of at least 2
  clk_div_legal_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_q |-> (clk_div_i >= 2) && !clk_div_i[0])
    else $error("illegal clock divider %0d", clk_div_i);

endmodule

`default_nettype wire

/* logic/serial_link_cfg_regs.sv */
// Serial link configuration registers
// Link enable, clock divider and read-only status

`timescale 1ns/1ps
`default_nettype none

`include "serial_link_defines.svh"

module serial_link_cfg_regs
  import serial_link_pkg::*;
(
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic                    cfg_we_i,
  input  wire cfg_addr_e               cfg_addr_i,
  input  wire logic [31:0]             cfg_wdata_i,
  output logic [31:0]                  cfg_rdata_o,
  output logic                         link_en_o,
  output logic [`SL_DIV_W-1:0]         clk_div_o,
  input  wire logic [`SL_CREDIT_W-1:0] credits_i,
  input  wire logic [`SL_CREDIT_W-1:0] rx_fill_i
);

  logic                 link_en_q;
  logic [`SL_DIV_W-1:0] clk_div_q;

  // Status is read-only, writes there fall through
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      link_en_q <= 1'b0;
      clk_div_q <= `SL_DIV_W'(`SL_RESET_CLK_DIV);
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        CFG_CTRL:    link_en_q <= cfg_wdata_i[0];
        CFG_CLK_DIV: clk_div_q <= cfg_wdata_i[`SL_DIV_W-1:0];
        default:     ;
      endcase
    end
  end

  always_comb begin
    cfg_rdata_o = '0;
    case (cfg_addr_i)
      CFG_CTRL:    cfg_rdata_o[0]             = link_en_q;
      CFG_CLK_DIV: cfg_rdata_o[`SL_DIV_W-1:0] = clk_div_q;
      CFG_STATUS: begin
        cfg_rdata_o[2:0] = credits_i;
        cfg_rdata_o[6:4] = rx_fill_i;
      end
      default:     cfg_rdata_o = '0;
    endcase
  end

  assign link_en_o = link_en_q;
  assign clk_div_o = clk_div_q;

endmodule

`default_nettype wire

/* logic/serial_link.sv */
// Serial link top level
// Network, data link and physical layers with configuration registers

`timescale 1ns/1ps
`default_nettype none

`include "serial_link_defines.svh"

module serial_link
  import serial_link_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  // User send
  input  wire logic                      msg_send_i,
  input  wire logic [`SL_DATA_W-1:0]     msg_data_i,
  output logic                           tx_ready_o,
  // User receive
  output logic                           rx_valid_o,
  output logic [`SL_DATA_W-1:0]          rx_data_o,
  input  wire logic                      rx_pop_i,
  // Registers
  input  wire logic                      cfg_we_i,
  input  wire cfg_addr_e                 cfg_addr_i,
  input  wire logic [31:0]               cfg_wdata_i,
  output logic [31:0]                    cfg_rdata_o,
  // Wire side
  output logic [`SL_NUM_LANES-1:0]       lanes_o,
  output logic                           fwd_clk_o,
  input  wire logic [`SL_NUM_LANES-1:0]  lanes_i,
  input  wire logic                      fwd_clk_i
);

  logic                     link_en;
  logic [`SL_DIV_W-1:0]     clk_div;
  logic [`SL_CREDIT_W-1:0]  credits;
  logic [`SL_CREDIT_W-1:0]  rx_fill;

  payload_t                 tx_payload;
  logic                     tx_payload_valid;
  logic                     tx_busy;
  payload_t                 rx_payload;
  logic                     rx_payload_valid;

  logic [`SL_NUM_LANES-1:0] beat_data;
  logic                     beat_send;
  logic                     beat_busy;
  logic [`SL_NUM_LANES-1:0] rx_beat;
  logic                     rx_beat_valid;

  ////////////////////////////////////////////////////////////
  // Layers
  ////////////////////////////////////////////////////////////

  serial_link_network u_network (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .link_en_i          ( link_en          ),
    .msg_send_i         ( msg_send_i       ),
    .msg_data_i         ( msg_data_i       ),
    .tx_ready_o         ( tx_ready_o       ),
    .rx_valid_o         ( rx_valid_o       ),
    .rx_data_o          ( rx_data_o        ),
    .rx_pop_i           ( rx_pop_i         ),
    .tx_payload_o       ( tx_payload       ),
    .tx_payload_valid_o ( tx_payload_valid ),
    .tx_busy_i          ( tx_busy          ),
    .rx_payload_i       ( rx_payload       ),
    .rx_payload_valid_i ( rx_payload_valid ),
    .credits_o          ( credits          ),
    .rx_fill_o          ( rx_fill          )
  );

  serial_link_data_link u_data_link (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .tx_payload_i       ( tx_payload       ),
    .tx_payload_valid_i ( tx_payload_valid ),
    .tx_busy_o          ( tx_busy          ),
    .rx_payload_o       ( rx_payload       ),
    .rx_payload_valid_o ( rx_payload_valid ),
    .beat_data_o        ( beat_data        ),
    .beat_send_o        ( beat_send        ),
    .beat_busy_i        ( beat_busy        ),
    .rx_beat_i          ( rx_beat          ),
    .rx_beat_valid_i    ( rx_beat_valid    )
  );

  serial_link_physical u_physical (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .clk_div_i       ( clk_div       ),
    .beat_data_i     ( beat_data     ),
    .beat_send_i     ( beat_send     ),
    .beat_busy_o     ( beat_busy     ),
    .rx_beat_o       ( rx_beat       ),
    .rx_beat_valid_o ( rx_beat_valid ),
    .lanes_o         ( lanes_o       ),
    .fwd_clk_o       ( fwd_clk_o     ),
    .lanes_i         ( lanes_i       ),
    .fwd_clk_i       ( fwd_clk_i     )
  );

  ////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////

  serial_link_cfg_regs u_cfg_regs (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .link_en_o   ( link_en     ),
    .clk_div_o   ( clk_div     ),
    .credits_i   ( credits     ),
    .rx_fill_i   ( rx_fill     )
  );

endmodule

`default_nettype wire

/* tb/tb_serial_link.sv */
// Loopback testbench for the serial link
// Xorshift message data, STATUS reference model and in-order data compare
// Credit back-pressure, divider sweep and link disable checks

`timescale 1ns/1ps
`default_nettype none

`include "serial_link_defines.svh"

module tb_serial_link
  import serial_link_pkg::*;
();

  localparam int CLK_HALF    = 20;
  localparam int DRIVE_DLY   = 2;
  localparam int WAIT_CYCLES = 4000;
  localparam int NUM_SINGLE  = 20;
  localparam int BURST_LEN   = 6;
  localparam int QUIET_LEN   = 200;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     msg_send_i;
  logic [`SL_DATA_W-1:0]    msg_data_i;
  logic                     tx_ready_o;
  logic                     rx_valid_o;
  logic [`SL_DATA_W-1:0]    rx_data_o;
  logic                     rx_pop_i;
  logic                     cfg_we_i;
  cfg_addr_e                cfg_addr_i;
  logic [31:0]              cfg_wdata_i;
  logic [31:0]              cfg_rdata_o;
  logic [`SL_NUM_LANES-1:0] lanes;
  logic                     fwd_clk;

  // Scoreboard state
  logic [`SL_DATA_W-1:0]    exp_q[$];
  logic [31:0]              rng_state;
  logic                     auto_pop;
  int                       sent_cnt;
  int                       pop_cnt;

  // Lanes and forwarded clock looped straight back
  serial_link UUT (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .msg_send_i  ( msg_send_i  ),
    .msg_data_i  ( msg_data_i  ),
    .tx_ready_o  ( tx_ready_o  ),
    .rx_valid_o  ( rx_valid_o  ),
    .rx_data_o   ( rx_data_o   ),
    .rx_pop_i    ( rx_pop_i    ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .lanes_o     ( lanes       ),
    .fwd_clk_o   ( fwd_clk     ),
    .lanes_i     ( lanes       ),
    .fwd_clk_i   ( fwd_clk     )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Inputs change at +2, outputs are read at +3
  task automatic drive_point();
    @(posedge clk_i);
    #(DRIVE_DLY);
  endtask

  task automatic sample_point();
    @(posedge clk_i);
    #(DRIVE_DLY + 1);
  endtask

  task automatic stop_on_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_now(input string why);
    $display("%s at %0t ns", why, $time);
    stop_on_failure();
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is 0x%08h, expected 0x%08h",
               $time, what, actual, expected);
      stop_on_failure();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Once idle every unpopped message holds one credit and one FIFO slot
  function automatic logic [31:0] expected_status(input int sent, input int popped);
    int          unpopped;
    logic [31:0] status;
    unpopped    = sent - popped;
    status      = '0;
    status[2:0] = 3'(`SL_NUM_CREDITS - unpopped);
    status[6:4] = 3'(unpopped);
    return status;
  endfunction

  task automatic write_reg(input cfg_addr_e addr, input logic [31:0] data);
    drive_point();
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    drive_point();
    cfg_we_i    = 1'b0;
  endtask

  // Read data is combinational from the address
  task automatic read_reg(input cfg_addr_e addr, output logic [31:0] data);
    drive_point();
    cfg_addr_i = addr;
    #1;
    data = cfg_rdata_o;
  endtask

  task automatic send_msg(input logic [`SL_DATA_W-1:0] data);
    drive_point();
    msg_send_i = 1'b1;
    msg_data_i = data;
    #1;
    exp_q.push_back(data);
    sent_cnt++;
    drive_point();
    msg_send_i = 1'b0;
  endtask

  task automatic set_auto_pop(input logic en);
    sample_point();
    auto_pop = en;
  endtask

  ////////////////////////////////////////////////////////////
  // Bounded waits
  ////////////////////////////////////////////////////////////

  task automatic wait_tx_ready();
    int cycles;
    cycles = 0;
    sample_point();
    while (tx_ready_o !== 1'b1) begin
      if (cycles >= WAIT_CYCLES) begin
        fail_now("tx_ready_o did not rise before timeout");
      end
      cycles++;
      sample_point();
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    sample_point();
    while (exp_q.size() != 0) begin
      if (cycles >= WAIT_CYCLES) begin
        fail_now("sent messages did not all come back before timeout");
      end
      cycles++;
      sample_point();
    end
  endtask

  task automatic wait_idle_status();
    logic [31:0] status;
    logic [31:0] expected;
    int          cycles;
    expected = expected_status(sent_cnt, pop_cnt);
    cycles   = 0;
    read_reg(CFG_STATUS, status);
    while (status !== expected) begin
      if (cycles >= WAIT_CYCLES) begin
        check_equal(status, expected, "STATUS after settle timeout");
      end
      cycles++;
      read_reg(CFG_STATUS, status);
    end
  endtask

  task automatic wait_fifo_full();
    logic [31:0] status;
    int          cycles;
    cycles = 0;
    read_reg(CFG_STATUS, status);
    while (status[6:4] != 3'(`SL_NUM_CREDITS)) begin
      if (cycles >= WAIT_CYCLES) begin
        fail_now("receive FIFO did not fill before timeout");
      end
      cycles++;
      read_reg(CFG_STATUS, status);
    end
  endtask

  task automatic check_tx_blocked(input int cycles);
    repeat (cycles) begin
      sample_point();
      check_equal(32'(tx_ready_o), 32'd0, "tx_ready_o without credits");
    end
  endtask

  task automatic check_link_silent(input int cycles);
    repeat (cycles) begin
      sample_point();
      check_equal(32'(tx_ready_o), 32'd0, "tx_ready_o with link disabled");
      check_equal(32'(rx_valid_o), 32'd0, "rx_valid_o with link disabled");
    end
  endtask

  task automatic run_burst(input int div);
    logic [31:0] rdata;
    write_reg(CFG_CLK_DIV, 32'(div));
    read_reg(CFG_CLK_DIV, rdata);
    check_equal(rdata, 32'(div), "CFG_CLK_DIV readback");
    for (int i = 0; i < BURST_LEN; i++) begin
      wait_tx_ready();
      rng_state = xorshift32(rng_state);
      send_msg(rng_state);
    end
    wait_drained();
    wait_idle_status();
  endtask

  ////////////////////////////////////////////////////////////
  // Receive compare
  ////////////////////////////////////////////////////////////

  // Pops the head whenever enabled and checks it against send order
  initial begin : compare_proc
    logic [`SL_DATA_W-1:0] exp_data;
    rx_pop_i = 1'b0;
    forever begin
      drive_point();
      rx_pop_i = 1'b0;
      if (auto_pop && rx_valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          fail_now("data arrived with no message outstanding");
        end
        exp_data = exp_q.pop_front();
        check_equal(rx_data_o, exp_data, "received data");
        rx_pop_i = 1'b1;
        pop_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : main_proc
    logic [31:0] rdata;
    rst_n_i     = 1'b0;
    msg_send_i  = 1'b0;
    msg_data_i  = '0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = CFG_CTRL;
    cfg_wdata_i = '0;
    rng_state   = 32'h6921;
    auto_pop    = 1'b1;
    sent_cnt    = 0;
    pop_cnt     = 0;
    repeat (2) drive_point();
    rst_n_i = 1'b1;

    // Reset state
    sample_point();
    check_equal(32'(tx_ready_o), 32'd0, "tx_ready_o after reset");
    check_equal(32'(rx_valid_o), 32'd0, "rx_valid_o after reset");
    check_equal(32'(fwd_clk), 32'd0, "fwd_clk_o after reset");
    check_equal(32'(lanes), 32'd0, "lanes_o after reset");
    read_reg(CFG_CLK_DIV, rdata);
    check_equal(rdata, 32'(`SL_RESET_CLK_DIV), "CFG_CLK_DIV after reset");
    read_reg(CFG_STATUS, rdata);
    check_equal(rdata, expected_status(0, 0), "CFG_STATUS after reset");

    // Single messages, each popped on arrival
    write_reg(CFG_CTRL, 32'd1);
    read_reg(CFG_CTRL, rdata);
    check_equal(rdata, 32'd1, "CFG_CTRL readback");
    for (int i = 0; i < NUM_SINGLE; i++) begin
      wait_tx_ready();
      rng_state = xorshift32(rng_state);
      send_msg(rng_state);
      wait_drained();
    end
    wait_idle_status();

    // Fill the FIFO and hold it, credits run out
    set_auto_pop(1'b0);
    for (int i = 0; i < `SL_NUM_CREDITS; i++) begin
      wait_tx_ready();
      rng_state = xorshift32(rng_state);
      send_msg(rng_state);
    end
    wait_fifo_full();
    read_reg(CFG_STATUS, rdata);
    check_equal(rdata, expected_status(sent_cnt, pop_cnt), "CFG_STATUS with full FIFO");
    check_equal(32'(rx_valid_o), 32'd1, "rx_valid_o with full FIFO");
    check_tx_blocked(50);
    set_auto_pop(1'b1);
    wait_drained();
    wait_tx_ready();
    wait_idle_status();

    // Fastest and a slow forwarded clock
    run_burst(2);
    run_burst(12);

    // Disabled link stays quiet
    write_reg(CFG_CTRL, 32'd0);
    check_link_silent(QUIET_LEN);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+logic
logic/serial_link_pkg.sv
logic/serial_link_network.sv
logic/serial_link_data_link.sv
logic/serial_link_physical.sv
logic/serial_link_cfg_regs.sv
logic/serial_link.sv
tb/tb_serial_link.sv

/* run.sh */
#!/bin/sh
# Build the loopback testbench with Verilator and run it

cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --timescale 1ns/1ps \
       --top-module tb_serial_link -f build.f \
  && ./obj_dir/Vtb_serial_link | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
